//--- Makefile
TOP := decodeExecuteTb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): vlog.f $(wildcard verilog/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/decodeExecuteTb.sv
module decodeExecuteTb import isaPkg::*; import pipePkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Preload of 32 and a program under 40 leave wide margin
  localparam int MaxCycles = 400;

  logic        Clock;
  logic        rstN;
  logic        inValid;
  instrT       inInstr;
  logic [31:0] inPcPlusFour;
  logic        inReady;
  wbT          wbIn;
  exMemT       exOut;

  // Reference state
  logic [31:0] regModel [32];
  exMemT       expQ [$];
  int          dueQ [$];
  exMemT       expHead;
  int          headDue;
  logic        headValid;
  logic        arrivalOk;
  logic [4:0]  loadInIdEx;
  logic [31:0] pcNext;
  int          seed;
  int          cycleCount;
  int          issuedCount;
  int          comparedCount;
  int          stallCount;

  // Snapshots taken just after the falling edge
  logic        readySnap;
  logic        stallExp;
  logic        issueStarted;

  decodeExecuteTop #(.NumRegs(32)) uut (
    .Clock        (Clock),
    .rstN         (rstN),
    .inValid      (inValid),
    .inInstr      (inInstr),
    .inPcPlusFour (inPcPlusFour),
    .inReady      (inReady),
    .wbIn         (wbIn),
    .exOut        (exOut)
  );

  always #50 Clock = ~Clock;

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  //////////////////////////////
  // Instruction builders
  //////////////////////////////

  function automatic instrT rWord(input functT fn, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [4:0] rd,
                                  input logic [4:0] sh);
    instrT w;
    w.r.opcode = OpRtype;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.shamt = sh;
    w.r.funct = fn;
    return w;
  endfunction

  function automatic instrT iWord(input opcodeT op, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [15:0] imm);
    instrT w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  function automatic instrT jWord(input opcodeT op, input logic [25:0] idx);
    instrT w;
    w.j.opcode = op;
    w.j.instrIndex = idx;
    return w;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // True when w uses register idx as a source operand
  function automatic logic readsReg(input instrT w, input logic [4:0] idx);
    logic rsUsed;
    logic rtUsed;
    rsUsed = 1'b0;
    rtUsed = 1'b0;
    case (w.r.opcode)
      OpRtype: begin
        // Shifts take only rt and jr only rs
        rsUsed = !(w.r.funct inside {FnSll, FnSrl});
        rtUsed = w.r.funct != FnJr;
      end
      OpAddi, OpSlti, OpAndi, OpOri, OpLw: rsUsed = 1'b1;
      OpSw, OpBeq, OpBne: begin
        rsUsed = 1'b1;
        rtUsed = 1'b1;
      end
      default: rsUsed = 1'b0;
    endcase
    return idx != 5'd0 && ((rsUsed && w.r.rs == idx) || (rtUsed && w.r.rt == idx));
  endfunction

  function automatic exMemT modelExecute(input instrT w, input logic [31:0] pc4);
    exMemT e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    e = '0;
    e.valid = 1'b1;
    a = regModel[w.r.rs];
    b = regModel[w.r.rt];
    sx = {{16{w.i.imm[15]}}, w.i.imm};
    zx = {16'h0000, w.i.imm};
    case (w.r.opcode)
      OpRtype: begin
        e.regWrite = 1'b1;
        e.destIdx = w.r.rd;
        case (w.r.funct)
          FnAdd: e.aluResult = a + b;
          FnSub: e.aluResult = a - b;
          FnAnd: e.aluResult = a & b;
          FnOr:  e.aluResult = a | b;
          FnSlt: e.aluResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FnSll: e.aluResult = b << w.r.shamt;
          FnSrl: e.aluResult = b >> w.r.shamt;
          FnJr: begin
            e.regWrite = 1'b0;
            e.destIdx = 5'd0;
            e.branchTaken = 1'b1;
            e.branchTarget = a;
          end
          default: e.regWrite = 1'b0;
        endcase
      end
      // Arithmetic immediates sign-extend and logical ones zero-extend
      OpAddi: e.aluResult = a + sx;
      OpSlti: e.aluResult = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      OpAndi: e.aluResult = a & zx;
      OpOri:  e.aluResult = a | zx;
      OpLui:  e.aluResult = {w.i.imm, 16'h0000};
      OpLw: begin
        e.memRead = 1'b1;
        e.memToReg = 1'b1;
        e.aluResult = a + sx;
      end
      OpSw: begin
        e.memWrite = 1'b1;
        e.aluResult = a + sx;
        e.storeData = b;
      end
      OpBeq, OpBne: begin
        e.branchTaken = (w.r.opcode == OpBeq) ? (a == b) : (a != b);
        e.branchTarget = pc4 + {sx[29:0], 2'b00};
      end
      OpJ, OpJal: begin
        e.branchTaken = 1'b1;
        e.branchTarget = {pc4[31:28], w.j.instrIndex, 2'b00};
      end
      default: e.valid = 1'b1;
    endcase
    // I-format writers target rt
    if (w.r.opcode inside {OpAddi, OpSlti, OpAndi, OpOri, OpLui, OpLw}) begin
      e.regWrite = 1'b1;
      e.destIdx = w.i.rt;
    end
    if (w.r.opcode == OpJal) begin
      e.regWrite = 1'b1;
      e.destIdx = 5'd31;
      e.aluResult = pc4 + 32'd4;
    end
    return e;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic preload();
    logic [31:0] data;
    for (int i = 0; i < 32; i++) begin
      @(negedge Clock);
      data = $random(seed);
      wbIn.writeEnable = 1'b1;
      wbIn.writeIdx = i[4:0];
      wbIn.writeData = data;
      // r0 write is dropped by the DUT
      regModel[i] = (i == 0) ? 32'h0 : data;
    end
    @(negedge Clock);
    wbIn = '0;
  endtask

  // Present one instruction until the DUT takes it
  task automatic issue(input instrT w);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge Clock);
      inValid = 1'b1;
      inInstr = w;
      inPcPlusFour = pcNext;
      #1;
      issueStarted = 1'b1;
      stallExp = readsReg(w, loadInIdEx);
      accepted = inReady;
      if (accepted) begin
        expQ.push_back(modelExecute(w, pcNext));
        // Two edges to exOut
        dueQ.push_back(cycleCount + 2);
        issuedCount++;
        pcNext = pcNext + 32'd4;
        loadInIdEx = (w.r.opcode == OpLw) ? w.i.rt : 5'd0;
      end else begin
        // Bubble now in idEx
        stallCount++;
        loadInIdEx = 5'd0;
      end
    end
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  always @(posedge Clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      reportFail($sformatf("Timeout, run went past %0d cycles", MaxCycles));
    end
  end

  always @(negedge Clock) begin
    #1;
    readySnap = inReady;
  end

  // Pop the expected entry after exOut settles
  always @(posedge Clock) begin
    #1;
    if (rstN && exOut.valid) begin
      headValid = expQ.size() != 0;
      if (headValid) begin
        expHead = expQ.pop_front();
        headDue = dueQ.pop_front();
        arrivalOk = headDue == cycleCount;
        comparedCount++;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  idleAfterReset: assert property (@(negedge Clock) disable iff (!rstN)
    !issueStarted |-> !exOut.valid && readySnap)
    else reportFail($sformatf("[ERROR] idle exOut.valid = %h, inReady = %h",
                              exOut.valid, readySnap));

  readyCheck: assert property (@(negedge Clock) disable iff (!rstN)
    readySnap == !stallExp)
    else reportFail($sformatf("[ERROR] inReady = %h, expected %h", readySnap, !stallExp));

  bubbleCheck: assert property (@(negedge Clock) disable iff (!rstN)
    !readySnap |=> !exOut.valid)
    else reportFail($sformatf("[ERROR] exOut.valid = %h after stall, expected 0",
                              exOut.valid));

  noOrphan: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid |-> headValid)
    else reportFail("exOut carried a valid entry that no accepted instruction explains");

  arrivalCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid |-> arrivalOk)
    else reportFail($sformatf("[ERROR] exOut arrival cycle = %h, expected %h",
                              cycleCount, headDue));

  enableCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid |-> {exOut.regWrite, exOut.memToReg, exOut.memRead, exOut.memWrite}
                    == {expHead.regWrite, expHead.memToReg, expHead.memRead, expHead.memWrite})
    else reportFail($sformatf("[ERROR] exOut enables = %h, expected %h",
      {exOut.regWrite, exOut.memToReg, exOut.memRead, exOut.memWrite},
      {expHead.regWrite, expHead.memToReg, expHead.memRead, expHead.memWrite}));

  destCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid && expHead.regWrite |-> exOut.destIdx == expHead.destIdx)
    else reportFail($sformatf("[ERROR] exOut.destIdx = %h, expected %h",
                              exOut.destIdx, expHead.destIdx));

  // Result only matters for writers and memory ops
  aluCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid && (expHead.regWrite || expHead.memRead || expHead.memWrite)
    |-> exOut.aluResult == expHead.aluResult)
    else reportFail($sformatf("[ERROR] exOut.aluResult = %h, expected %h",
                              exOut.aluResult, expHead.aluResult));

  storeCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid && expHead.memWrite |-> exOut.storeData == expHead.storeData)
    else reportFail($sformatf("[ERROR] exOut.storeData = %h, expected %h",
                              exOut.storeData, expHead.storeData));

  takenCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid |-> exOut.branchTaken == expHead.branchTaken)
    else reportFail($sformatf("[ERROR] exOut.branchTaken = %h, expected %h",
                              exOut.branchTaken, expHead.branchTaken));

  targetCheck: assert property (@(negedge Clock) disable iff (!rstN)
    exOut.valid |-> exOut.branchTarget == expHead.branchTarget)
    else reportFail($sformatf("[ERROR] exOut.branchTarget = %h, expected %h",
                              exOut.branchTarget, expHead.branchTarget));

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    Clock = 1'b0;
    rstN = 1'b0;
    inValid = 1'b0;
    inInstr = '0;
    inPcPlusFour = '0;
    wbIn = '0;
    expHead = '0;
    headDue = 0;
    headValid = 1'b0;
    arrivalOk = 1'b0;
    loadInIdEx = 5'd0;
    // Upper nibble nonzero so jump targets keep it
    pcNext = 32'h9000_1004;
    seed = 25555;
    cycleCount = 0;
    issuedCount = 0;
    comparedCount = 0;
    stallCount = 0;
    readySnap = 1'b1;
    stallExp = 1'b0;
    issueStarted = 1'b0;

    // Two rising edges in reset
    repeat (2) @(posedge Clock);
    @(negedge Clock);
    rstN = 1'b1;

    preload();

    // R-type ops with shifts and an r0 source
    issue(rWord(FnAdd, 5'd1, 5'd2, 5'd10, 5'd0));
    issue(rWord(FnSub, 5'd3, 5'd4, 5'd11, 5'd0));
    issue(rWord(FnAnd, 5'd5, 5'd6, 5'd12, 5'd0));
    issue(rWord(FnOr, 5'd7, 5'd8, 5'd13, 5'd0));
    issue(rWord(FnSlt, 5'd9, 5'd1, 5'd14, 5'd0));
    issue(rWord(FnSll, 5'd0, 5'd2, 5'd15, 5'd5));
    issue(rWord(FnSrl, 5'd0, 5'd3, 5'd16, 5'd7));
    issue(rWord(FnAdd, 5'd0, 5'd4, 5'd17, 5'd0));

    // Immediates with top bit set
    issue(iWord(OpAddi, 5'd5, 5'd18, 16'hfff0));
    issue(iWord(OpSlti, 5'd6, 5'd19, 16'h8001));
    issue(iWord(OpAndi, 5'd7, 5'd20, 16'hf0f0));
    issue(iWord(OpOri, 5'd8, 5'd21, 16'h8001));
    issue(iWord(OpLui, 5'd0, 5'd22, 16'hbeef));

    // Load-use stall then independent and r0 loads
    issue(iWord(OpLw, 5'd9, 5'd23, 16'hfffc));
    issue(rWord(FnAdd, 5'd23, 5'd1, 5'd24, 5'd0));
    issue(iWord(OpLw, 5'd2, 5'd25, 16'h0010));
    issue(rWord(FnOr, 5'd3, 5'd4, 5'd26, 5'd0));
    issue(iWord(OpLw, 5'd5, 5'd0, 16'h0004));
    issue(rWord(FnAdd, 5'd0, 5'd0, 5'd27, 5'd0));
    issue(iWord(OpSw, 5'd7, 5'd6, 16'h0020));

    // Branches both ways then jumps
    issue(iWord(OpBeq, 5'd5, 5'd5, 16'h0010));
    issue(iWord(OpBeq, 5'd1, 5'd2, 16'hfff8));
    issue(iWord(OpBne, 5'd1, 5'd2, 16'h0004));
    issue(iWord(OpBne, 5'd5, 5'd5, 16'h0008));
    issue(jWord(OpJ, 26'h123_4567));
    issue(jWord(OpJal, 26'h0ab_cdef));
    issue(rWord(FnJr, 5'd8, 5'd0, 5'd0, 5'd0));

    @(negedge Clock);
    inValid = 1'b0;
    #1;
    stallExp = 1'b0;
    loadInIdEx = 5'd0;

    // Wait for the queue to drain
    while (expQ.size() != 0) begin
      @(negedge Clock);
    end
    repeat (2) @(negedge Clock);

    if (comparedCount == issuedCount && stallCount == 1) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      reportFail($sformatf("Run ended with %0d of %0d entries compared and %0d stalls",
                           comparedCount, issuedCount, stallCount));
    end
  end

endmodule

//--- verilog/decodeExecuteTop.sv
module decodeExecuteTop import isaPkg::*; import pipePkg::*; #(
  parameter int NumRegs = 32
) (
  input  logic        Clock,
  input  logic        rstN,
  input  logic        inValid,
  input  instrT       inInstr,
  input  logic [31:0] inPcPlusFour,
  output logic        inReady,
  input  wbT          wbIn,
  output exMemT       exOut
);

  ctrlT        decCtrl;
  logic [31:0] decImm32;
  logic [4:0]  decDestIdx;
  logic        decIllegal;
  logic [31:0] regData1;
  logic [31:0] regData2;
  logic        readsRs;
  logic        readsRt;
  logic        take;
  logic        insertBubble;
  idExT        idExIn;
  idExT        idEx;

  //////////////////////////////
  // Decode stage
  //////////////////////////////

  instrDecoder uDecoder (
    .instr   (inInstr),
    .ctrl    (decCtrl),
    .imm32   (decImm32),
    .destIdx (decDestIdx),
    .illegal (decIllegal)
  );

  regFile #(.NumRegs(NumRegs)) uRegFile (
    .Clock    (Clock),
    .rstN     (rstN),
    .rsIdx    (inInstr.r.rs),
    .rtIdx    (inInstr.r.rt),
    .regData1 (regData1),
    .regData2 (regData2),
    .wb       (wbIn)
  );

  // Which source fields are real operands
  // Jumps and shifts leave rs unused, lui has no sources
  assign readsRs = !(decCtrl.branchSel inside {BrJump, BrJumpLink})
                   && !decCtrl.useShamt && decCtrl.aluOp != AluLui;
  // rt read by register ALU ops, branches and stores
  assign readsRt = (decCtrl.srcBSel == SrcBReg
                    && !(decCtrl.branchSel inside {BrJump, BrJumpLink, BrJumpReg}))
                   || decCtrl.memWrite;

  hazardUnit uHazard (
    .idEx         (idEx),
    .rsIdx        (inInstr.r.rs),
    .rtIdx        (inInstr.r.rt),
    .readsRs      (readsRs),
    .readsRt      (readsRt),
    .inValid      (inValid),
    .inReady      (inReady),
    .insertBubble (insertBubble)
  );

  assign take = inValid && inReady;

  // Decode bundle, illegal words enter as empty slots
  assign idExIn.valid = !decIllegal;
  assign idExIn.ctrl = decCtrl;
  assign idExIn.pcPlusFour = inPcPlusFour;
  assign idExIn.regData1 = regData1;
  assign idExIn.regData2 = regData2;
  assign idExIn.imm32 = decImm32;
  assign idExIn.shamt = inInstr.r.shamt;
  assign idExIn.rsIdx = inInstr.r.rs;
  assign idExIn.rtIdx = inInstr.r.rt;
  assign idExIn.destIdx = decDestIdx;
  assign idExIn.instrIndex = inInstr.j.instrIndex;

  //////////////////////////////
  // Execute stage
  //////////////////////////////

  decodeToExecute uIdEx (
    .Clock        (Clock),
    .rstN         (rstN),
    .take         (take),
    .insertBubble (insertBubble),
    .dIn          (idExIn),
    .dOut         (idEx)
  );

  executeUnit uExecute (
    .Clock (Clock),
    .rstN  (rstN),
    .idEx  (idEx),
    .exOut (exOut)
  );

endmodule

//--- verilog/decodeToExecute.sv
module decodeToExecute import pipePkg::*; (
  input  logic Clock,
  input  logic rstN,
  input  logic take,
  input  logic insertBubble,
  input  idExT dIn,
  output idExT dOut
);

  logic kill;

  // Nothing accepted, or load-use stall
  assign kill = insertBubble || !take;

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_ff @(posedge Clock) begin
    // Data fields load every cycle
    dOut <= dIn;
    if (!rstN || kill) begin
      // Empty slot, nothing may write or branch
      dOut.valid <= 1'b0;
      dOut.ctrl.regWrite <= 1'b0;
      dOut.ctrl.memToReg <= 1'b0;
      dOut.ctrl.memRead <= 1'b0;
      dOut.ctrl.memWrite <= 1'b0;
      dOut.ctrl.branchSel <= BrNone;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Empty slot carries no side effects into execute
  emptyNoWrite: assert property (@(posedge Clock) disable iff (!rstN)
    !dOut.valid |-> !dOut.ctrl.regWrite && !dOut.ctrl.memWrite)
    else $error("idEx empty slot regWrite=%h memWrite=%h",
                dOut.ctrl.regWrite, dOut.ctrl.memWrite);

  // One bubble clears the load, so no second stall cycle
  singleStall: assert property (@(posedge Clock) disable iff (!rstN)
    insertBubble |=> !insertBubble)
    else $error("inReady low two cycles running");

endmodule

//--- verilog/executeUnit.sv
module executeUnit import pipePkg::*; (
  input  logic  Clock,
  input  logic  rstN,
  input  idExT  idEx,
  output exMemT exOut
);

  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] aluResult;
  logic [31:0] memAddr;
  logic [31:0] branchOffset;
  logic        regsEqual;
  exMemT       exNext;

  //////////////////////////////
  // Operands
  //////////////////////////////

  // Shift amount replaces rs for sll and srl
  assign srcA = idEx.ctrl.useShamt ? {27'b0, idEx.shamt} : idEx.regData1;

  always_comb begin
    if (idEx.ctrl.aluOp == AluLui) begin
      // Fixed shift of sixteen
      srcB = 32'd16;
    end else begin
      case (idEx.ctrl.srcBSel)
        SrcBSignImm, SrcBZeroImm: srcB = idEx.imm32;
        default: srcB = idEx.regData2;
      endcase
    end
  end

  //////////////////////////////
  // ALU
  //////////////////////////////

  always_comb begin
    case (idEx.ctrl.aluOp)
      AluAdd: aluResult = srcA + srcB;
      AluSub: aluResult = srcA - srcB;
      AluAnd: aluResult = srcA & srcB;
      AluOr:  aluResult = srcA | srcB;
      AluSlt: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
      // Register value in B, amount in A
      AluSll: aluResult = srcB << srcA[4:0];
      AluSrl: aluResult = srcB >> srcA[4:0];
      AluLui: aluResult = idEx.imm32 << srcB[4:0];
      default: aluResult = '0;
    endcase
  end

  // Base plus sign-extended offset
  assign memAddr = idEx.regData1 + idEx.imm32;

  // Word offset for conditional branches
  assign branchOffset = {idEx.imm32[29:0], 2'b00};
  assign regsEqual = idEx.regData1 == idEx.regData2;

  always_comb begin
    exNext.valid = idEx.valid;
    exNext.regWrite = idEx.ctrl.regWrite;
    exNext.memToReg = idEx.ctrl.memToReg;
    exNext.memRead = idEx.ctrl.memRead;
    exNext.memWrite = idEx.ctrl.memWrite;
    exNext.destIdx = idEx.destIdx;
    exNext.storeData = idEx.regData2;
    exNext.branchTaken = 1'b0;
    exNext.branchTarget = '0;

    if (idEx.ctrl.memRead || idEx.ctrl.memWrite) begin
      exNext.aluResult = memAddr;
    end else if (idEx.ctrl.branchSel == BrJumpLink) begin
      // Link skips the delay slot
      exNext.aluResult = idEx.pcPlusFour + 32'd4;
    end else begin
      exNext.aluResult = aluResult;
    end

    // Branch and jump resolution
    case (idEx.ctrl.branchSel)
      BrBeq, BrBne: begin
        exNext.branchTaken = (idEx.ctrl.branchSel == BrBeq) ? regsEqual : !regsEqual;
        exNext.branchTarget = idEx.pcPlusFour + branchOffset;
      end
      BrJump, BrJumpLink: begin
        exNext.branchTaken = 1'b1;
        exNext.branchTarget = {idEx.pcPlusFour[31:28], idEx.instrIndex, 2'b00};
      end
      BrJumpReg: begin
        exNext.branchTaken = 1'b1;
        exNext.branchTarget = idEx.regData1;
      end
      default: exNext.branchTaken = 1'b0;
    endcase
  end

  // Output register toward memory stage
  always_ff @(posedge Clock) begin
    exOut <= exNext;
    if (!rstN) begin
      exOut.valid <= 1'b0;
      exOut.regWrite <= 1'b0;
      exOut.memToReg <= 1'b0;
      exOut.memRead <= 1'b0;
      exOut.memWrite <= 1'b0;
      exOut.branchTaken <= 1'b0;
    end
  end

  // Load and store never merged in one entry
  memExclusive: assert property (@(posedge Clock) disable iff (!rstN)
    !(exOut.memRead && exOut.memWrite))
    else $error("exOut memRead=%h memWrite=%h", exOut.memRead, exOut.memWrite);

endmodule

//--- verilog/hazardUnit.sv
module hazardUnit import pipePkg::*; (
  input  idExT       idEx,
  input  logic [4:0] rsIdx,
  input  logic [4:0] rtIdx,
  input  logic       readsRs,
  input  logic       readsRt,
  input  logic       inValid,
  output logic       inReady,
  output logic       insertBubble
);

  logic loadInEx;
  logic rsHit;
  logic rtHit;
  logic loadUse;

  // Valid load headed for a real register
  assign loadInEx = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.regDst != 5'd0;

  // Source matches the load target
  assign rsHit = readsRs && rsIdx == idEx.ctrl.regDst;
  assign rtHit = readsRt && rtIdx == idEx.ctrl.regDst;

  // Only a presented instruction can stall
  assign loadUse = inValid && loadInEx && (rsHit || rtHit);

  // Hold input one cycle, bubble goes to execute
  assign inReady = !loadUse;
  assign insertBubble = loadUse;

endmodule

//--- verilog/instrDecoder.sv
module instrDecoder import isaPkg::*; import pipePkg::*; (
  input  instrT       instr,
  output ctrlT        ctrl,
  output logic [31:0] imm32,
  output logic [4:0]  destIdx,
  output logic        illegal
);

  logic [15:0] immField;
  logic        zeroExt;

  // Immediate always from the I view
  assign immField = instr.i.imm;

  // Logical ops and lui take the immediate unsigned
  assign imm32 = zeroExt ? {16'h0000, immField} : {{16{immField[15]}}, immField};

  always_comb begin
    // Everything off unless an opcode turns it on
    ctrl = '0;
    ctrl.aluOp = AluAdd;
    ctrl.srcBSel = SrcBReg;
    ctrl.branchSel = BrNone;
    destIdx = '0;
    zeroExt = 1'b0;
    illegal = 1'b0;

    case (instr.r.opcode)
      OpRtype: begin
        // R view with the result in rd
        destIdx = instr.r.rd;
        ctrl.regWrite = 1'b1;
        case (instr.r.funct)
          FnAdd: ctrl.aluOp = AluAdd;
          FnSub: ctrl.aluOp = AluSub;
          FnAnd: ctrl.aluOp = AluAnd;
          FnOr:  ctrl.aluOp = AluOr;
          FnSlt: ctrl.aluOp = AluSlt;
          FnSll: begin
            ctrl.aluOp = AluSll;
            ctrl.useShamt = 1'b1;
          end
          FnSrl: begin
            ctrl.aluOp = AluSrl;
            ctrl.useShamt = 1'b1;
          end
          FnJr: begin
            // Jump through rs without a write
            ctrl.regWrite = 1'b0;
            ctrl.branchSel = BrJumpReg;
            destIdx = '0;
          end
          default: begin
            ctrl.regWrite = 1'b0;
            destIdx = '0;
            illegal = 1'b1;
          end
        endcase
      end
      OpAddi, OpSlti: begin
        // I view with the result in rt
        ctrl.regWrite = 1'b1;
        ctrl.srcBSel = SrcBSignImm;
        ctrl.aluOp = (instr.i.opcode == OpSlti) ? AluSlt : AluAdd;
        destIdx = instr.i.rt;
      end
      OpAndi, OpOri: begin
        ctrl.regWrite = 1'b1;
        ctrl.srcBSel = SrcBZeroImm;
        ctrl.aluOp = (instr.i.opcode == OpOri) ? AluOr : AluAnd;
        destIdx = instr.i.rt;
        zeroExt = 1'b1;
      end
      OpLui: begin
        ctrl.regWrite = 1'b1;
        ctrl.srcBSel = SrcBZeroImm;
        ctrl.aluOp = AluLui;
        destIdx = instr.i.rt;
        zeroExt = 1'b1;
      end
      OpLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.srcBSel = SrcBSignImm;
        destIdx = instr.i.rt;
      end
      // Store data from rt and address from rs plus imm
      OpSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.srcBSel = SrcBSignImm;
      end
      OpBeq: begin
        ctrl.aluOp = AluSub;
        ctrl.branchSel = BrBeq;
      end
      OpBne: begin
        ctrl.aluOp = AluSub;
        ctrl.branchSel = BrBne;
      end
      // Target built later from instrIndex
      OpJ: ctrl.branchSel = BrJump;
      OpJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.branchSel = BrJumpLink;
        destIdx = 5'd31;
      end
      default: illegal = 1'b1;
    endcase

    ctrl.regDst = destIdx;
  end

endmodule

//--- verilog/isaPkg.sv
package isaPkg;

  //////////////////////////////
  // Primary opcode field
  //////////////////////////////

  typedef enum logic [5:0] {
    // Register format, funct decides
    OpRtype = 6'h00,
    // Absolute jump
    OpJ     = 6'h02,
    // Jump and link to r31
    OpJal   = 6'h03,
    // Branch on equal
    OpBeq   = 6'h04,
    // Branch on not equal
    OpBne   = 6'h05,
    // Add signed immediate
    OpAddi  = 6'h08,
    // Set less than immediate
    OpSlti  = 6'h0a,
    // And with zero-extended imm
    OpAndi  = 6'h0c,
    // Or with zero-extended imm
    OpOri   = 6'h0d,
    // Load upper half
    OpLui   = 6'h0f,
    // Load word
    OpLw    = 6'h23,
    // Store word
    OpSw    = 6'h2b
  } opcodeT;

  // R-type function codes
  typedef enum logic [5:0] {
    FnSll = 6'h00,
    FnSrl = 6'h02,
    FnJr  = 6'h08,
    FnAdd = 6'h20,
    FnSub = 6'h22,
    FnAnd = 6'h24,
    FnOr  = 6'h25,
    FnSlt = 6'h2a
  } functT;

  //////////////////////////////
  // Instruction formats
  //////////////////////////////

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    functT       funct;
  } rTypeT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeT;

  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] instrIndex;
  } jTypeT;

  // Same 32-bit word, three views
  // Opcode sits in the top six bits of every view
  typedef union packed {
    rTypeT r;
    iTypeT i;
    jTypeT j;
  } instrT;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

  //////////////////////////////
  // Control encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluSlt,
    AluSll,
    AluSrl,
    AluLui
  } aluOpT;

  // ALU B operand source
  typedef enum logic [1:0] {
    SrcBReg,
    SrcBSignImm,
    SrcBZeroImm
  } srcBSelT;

  // Branch and jump kind
  typedef enum logic [2:0] {
    BrNone,
    BrBeq,
    BrBne,
    BrJump,
    BrJumpLink,
    BrJumpReg
  } branchSelT;

  // Decoder output bundle
  typedef struct packed {
    logic      regWrite;
    logic      memToReg;
    logic      memRead;
    logic      memWrite;
    // Destination index, already chosen
    logic [4:0] regDst;
    aluOpT     aluOp;
    srcBSelT   srcBSel;
    logic      useShamt;
    branchSelT branchSel;
  } ctrlT;

  //////////////////////////////
  // Stage contents
  //////////////////////////////

  typedef struct packed {
    logic        valid;
    ctrlT        ctrl;
    logic [31:0] pcPlusFour;
    logic [31:0] regData1;
    logic [31:0] regData2;
    logic [31:0] imm32;
    logic [4:0]  shamt;
    logic [4:0]  rsIdx;
    logic [4:0]  rtIdx;
    logic [4:0]  destIdx;
    logic [25:0] instrIndex;
  } idExT;

  typedef struct packed {
    logic        valid;
    logic        regWrite;
    logic        memToReg;
    logic        memRead;
    logic        memWrite;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [4:0]  destIdx;
    logic        branchTaken;
    logic [31:0] branchTarget;
  } exMemT;

  // Write-back port into the register file
  typedef struct packed {
    logic        writeEnable;
    logic [4:0]  writeIdx;
    logic [31:0] writeData;
  } wbT;

endpackage

//--- verilog/regFile.sv
module regFile import pipePkg::*; #(
  parameter int NumRegs = 32
) (
  input  logic        Clock,
  input  logic        rstN,
  input  logic [4:0]  rsIdx,
  input  logic [4:0]  rtIdx,
  output logic [31:0] regData1,
  output logic [31:0] regData2,
  input  wbT          wb
);

  logic [31:0] regs [NumRegs];

  // One read port, with write bypass
  function automatic logic [31:0] readPort(
    input logic [4:0]  idx,
    input wbT          wbNow,
    input logic [31:0] stored
  );
    logic [31:0] val;
    if (idx == 5'd0 || idx >= NumRegs) begin
      val = '0;
    end else if (wbNow.writeEnable && wbNow.writeIdx == idx) begin
      // Same-cycle write wins over storage
      val = wbNow.writeData;
    end else begin
      val = stored;
    end
    return val;
  endfunction

  always_comb begin
    regData1 = readPort(rsIdx, wb, regs[rsIdx % NumRegs]);
    regData2 = readPort(rtIdx, wb, regs[rtIdx % NumRegs]);
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wb.writeEnable && wb.writeIdx != 5'd0 && wb.writeIdx < NumRegs) begin
      // r0 never written
      regs[wb.writeIdx] <= wb.writeData;
    end
  end

  // r0 hardwired to zero across all writes
  r0StaysZero: assert property (@(posedge Clock) disable iff (!rstN) regs[0] == '0)
    else $error("regFile r0 = %h", regs[0]);

endmodule

//--- vlog.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/decodeToExecute.sv
verilog/executeUnit.sv
verilog/decodeExecuteTop.sv
dv/decodeExecuteTb.sv
